//--- src/spindle_rack_pkg.sv
`default_nettype none

package spindle_rack_pkg;

    // widths that carry a meaning
    typedef logic [15:0] rate_t;        // afferent firing rate, integer pps
    typedef logic [15:0] gain_t;        // unsigned gain, 8 fractional bits
    typedef logic [31:0] current_t;     // neuron input current
    typedef logic [15:0] count_t;       // spikes per tick window
    typedef logic [31:0] time_t;        // time tag, ticks since reset
    typedef logic [31:0] param_word_t;  // host data word
    typedef logic [2:0]  param_addr_t;  // host register address

    // four-phase host write
    typedef enum logic {
        HOST_IDLE,  // waiting for req
        HOST_ACK    // ack held until req drops
    } host_state_t;

    // register map, 5..7 are acked and ignored
    localparam param_addr_t PARAM_ADDR_IA_OFFSET = 3'd0;
    localparam param_addr_t PARAM_ADDR_IA_GAIN   = 3'd1;
    localparam param_addr_t PARAM_ADDR_II_OFFSET = 3'd2;
    localparam param_addr_t PARAM_ADDR_II_GAIN   = 3'd3;
    localparam param_addr_t PARAM_ADDR_DIVIDER   = 3'd4;

    // values after reset
    localparam rate_t       RESET_IA_OFFSET = 16'd70;
    localparam gain_t       RESET_IA_GAIN   = 16'd307;   // 1.2 in 8.8
    localparam rate_t       RESET_II_OFFSET = 16'd50;
    localparam gain_t       RESET_II_GAIN   = 16'd512;   // 2.0 in 8.8
    localparam param_word_t RESET_DIVIDER   = 32'd381;   // half real-time speed

    // rate to current scaling
    localparam int GAIN_FRAC_BITS = 8;
    localparam int CURRENT_SHIFT  = 6;   // scaled rate to current units
    localparam int NOISE_BITS     = 11;  // low current bits carrying noise

    // galois lfsr, shifts right, x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam logic [31:0] SEED_IA   = 32'hACE1_2468;
    localparam logic [31:0] SEED_II   = 32'h1357_BDF1;

endpackage

`default_nettype wire

//--- src/param_bank.sv
`default_nettype none
`timescale 1ns/1ps

module param_bank (
    input  wire                             ep50trig,
    input  wire                             reset_global,
    input  wire logic                       i_host_req,
    input  wire spindle_rack_pkg::param_addr_t i_host_addr,
    input  wire spindle_rack_pkg::param_word_t i_host_data,
    output logic                            o_host_ack,
    output spindle_rack_pkg::rate_t         o_ia_offset,
    output spindle_rack_pkg::gain_t         o_ia_gain,
    output spindle_rack_pkg::rate_t         o_ii_offset,
    output spindle_rack_pkg::gain_t         o_ii_gain,
    output spindle_rack_pkg::param_word_t   o_divider
);

    spindle_rack_pkg::host_state_t host_state;
    logic                          wr_en;   // one-cycle write strobe

    // req sampled while idle, the write lands on that same edge
    assign wr_en = (host_state == spindle_rack_pkg::HOST_IDLE) && i_host_req;

    // ack straight from the state flop, high the cycle after the write
    assign o_host_ack = (host_state == spindle_rack_pkg::HOST_ACK);

    // four-phase handshake
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            host_state <= spindle_rack_pkg::HOST_IDLE;
        end
        else
        begin
            case (host_state)
                spindle_rack_pkg::HOST_IDLE:
                begin
                    if (i_host_req)
                        host_state <= spindle_rack_pkg::HOST_ACK;
                end
                spindle_rack_pkg::HOST_ACK:
                begin
                    if (!i_host_req)  // host let go, drop ack next cycle
                        host_state <= spindle_rack_pkg::HOST_IDLE;
                end
                default: host_state <= spindle_rack_pkg::HOST_IDLE;
            endcase
        end
    end

    // address decode into the five registers
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_ia_offset <= spindle_rack_pkg::RESET_IA_OFFSET;
            o_ia_gain   <= spindle_rack_pkg::RESET_IA_GAIN;
            o_ii_offset <= spindle_rack_pkg::RESET_II_OFFSET;
            o_ii_gain   <= spindle_rack_pkg::RESET_II_GAIN;
            o_divider   <= spindle_rack_pkg::RESET_DIVIDER;
        end
        else if (wr_en)
        begin
            case (i_host_addr)
                spindle_rack_pkg::PARAM_ADDR_IA_OFFSET:
                    o_ia_offset <= i_host_data[15:0];  // low half only
                spindle_rack_pkg::PARAM_ADDR_IA_GAIN:
                    o_ia_gain   <= i_host_data[15:0];
                spindle_rack_pkg::PARAM_ADDR_II_OFFSET:
                    o_ii_offset <= i_host_data[15:0];
                spindle_rack_pkg::PARAM_ADDR_II_GAIN:
                    o_ii_gain   <= i_host_data[15:0];
                spindle_rack_pkg::PARAM_ADDR_DIVIDER:
                    o_divider   <= i_host_data;        // full word
                default: ;                             // 5..7, ack only
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/sim_tick_gen.sv
`default_nettype none
`timescale 1ns/1ps

module sim_tick_gen (
    input  wire                             ep50trig,
    input  wire                             reset_global,
    input  wire spindle_rack_pkg::param_word_t i_divider,
    output logic                            o_sim_tick,
    output spindle_rack_pkg::time_t         o_time_tag
);

    spindle_rack_pkg::param_word_t tick_cnt;  // cycles into the current tick period

    // one cycle at the terminal count, period is divider+1
    assign o_sim_tick = (tick_cnt == i_divider);

    // divider counter
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            tick_cnt <= '0;
        end
        else if (o_sim_tick)
        begin
            tick_cnt <= '0;           // wrap on terminal count
        end
        else
        begin
            tick_cnt <= tick_cnt + 1'b1;  // a smaller divider waits for full wrap
        end
    end

    // time tag for latency measurement
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            o_time_tag <= '0;
        else if (o_sim_tick)
            o_time_tag <= o_time_tag + 1'b1;  // visible the cycle after the tick
    end

endmodule

`default_nettype wire

//--- src/afferent_channel.sv
`default_nettype none
`timescale 1ns/1ps

module afferent_channel #(
    parameter logic [31:0] P_SEED = spindle_rack_pkg::SEED_IA  // any nonzero value
) (
    input  wire                         ep50trig,
    input  wire                         reset_global,
    input  wire logic                   i_sim_tick,
    input  wire spindle_rack_pkg::rate_t i_rate,
    input  wire spindle_rack_pkg::rate_t i_offset,
    input  wire spindle_rack_pkg::gain_t i_gain,
    output spindle_rack_pkg::current_t  o_current
);

    spindle_rack_pkg::rate_t    rate_net;    // rate with offset removed
    logic [31:0]                gain_prod;   // 16x16 product, 8 fraction bits
    spindle_rack_pkg::current_t scaled;      // integer rate in current units
    spindle_rack_pkg::current_t mixed;       // scaled value with noise in low bits
    logic [31:0]                lfsr;
    logic [31:0]                lfsr_next;

    // offset removal, floor at zero
    assign rate_net = (i_rate > i_offset) ? (i_rate - i_offset) : '0;

    // gain, full width so nothing overflows
    assign gain_prod = rate_net * i_gain;

    // drop fraction, then shift up into current units
    assign scaled = (gain_prod >> spindle_rack_pkg::GAIN_FRAC_BITS)
                    << spindle_rack_pkg::CURRENT_SHIFT;

    // noise from the lfsr value before it advances
    assign mixed = {scaled[31:spindle_rack_pkg::NOISE_BITS],
                    lfsr[spindle_rack_pkg::NOISE_BITS-1:0]};

    // right-shifting galois step
    assign lfsr_next = (lfsr >> 1) ^ (lfsr[0] ? spindle_rack_pkg::LFSR_TAPS : 32'd0);

    // noise source, one step per tick
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            lfsr <= P_SEED;
        else if (i_sim_tick)
            lfsr <= lfsr_next;
    end

    // current register, held between ticks
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_current <= '0;
        end
        else if (i_sim_tick)
        begin
            o_current <= mixed;  // valid from the cycle after the tick
        end
    end

endmodule

`default_nettype wire

//--- src/spike_rate_counter.sv
`default_nettype none
`timescale 1ns/1ps

module spike_rate_counter (
    input  wire                      ep50trig,
    input  wire                      reset_global,
    input  wire logic                i_sim_tick,
    input  wire logic                i_spike,      // async, from the neuron array
    output spindle_rack_pkg::count_t o_spike_count
);

    logic                     spike_meta;   // first sync stage
    logic                     spike_sync;   // second sync stage
    logic                     spike_prev;   // delayed for edge detect
    logic                     spike_edge;
    spindle_rack_pkg::count_t run_cnt;      // count in the open window

    assign spike_edge = spike_sync & ~spike_prev;  // rising edge only

    // two-flop synchronizer plus edge delay
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            spike_meta <= 1'b0;
            spike_sync <= 1'b0;
            spike_prev <= 1'b0;
        end
        else
        begin
            spike_meta <= i_spike;
            spike_sync <= spike_meta;
            spike_prev <= spike_sync;
        end
    end

    // window count, latched and restarted on each tick
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            run_cnt       <= '0;
            o_spike_count <= '0;
        end
        else if (i_sim_tick)
        begin
            o_spike_count <= run_cnt;
            run_cnt       <= spike_edge ? 16'd1 : 16'd0;  // edge on the tick opens new window
        end
        else if (spike_edge && (run_cnt != '1))  // saturate at max
        begin
            run_cnt <= run_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/spindle_rack_top.sv
`default_nettype none
`timescale 1ns/1ps

module spindle_rack_top (
    input  wire                             ep50trig,
    input  wire                             reset_global,
    input  wire logic                       i_host_req,
    input  wire spindle_rack_pkg::param_addr_t i_host_addr,
    input  wire spindle_rack_pkg::param_word_t i_host_data,
    input  wire spindle_rack_pkg::rate_t    i_ia_rate,     // Ia afferent rate, pps
    input  wire spindle_rack_pkg::rate_t    i_ii_rate,     // II afferent rate, pps
    input  wire logic                       i_ia_spike,    // raw spikes, Ia neuron
    input  wire logic                       i_ii_spike,    // raw spikes, II neuron
    output logic                            o_host_ack,
    output logic                            o_sim_tick,
    output spindle_rack_pkg::time_t         o_time_tag,
    output spindle_rack_pkg::current_t      o_ia_current,
    output spindle_rack_pkg::current_t      o_ii_current,
    output spindle_rack_pkg::count_t        o_ia_spike_count,
    output spindle_rack_pkg::count_t        o_ii_spike_count
);

    spindle_rack_pkg::rate_t       ia_offset;
    spindle_rack_pkg::gain_t       ia_gain;
    spindle_rack_pkg::rate_t       ii_offset;
    spindle_rack_pkg::gain_t       ii_gain;
    spindle_rack_pkg::param_word_t divider;   // tick period minus one

    // host register bank
    param_bank u_param_bank (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_host_req   (i_host_req),
        .i_host_addr  (i_host_addr),
        .i_host_data  (i_host_data),
        .o_host_ack   (o_host_ack),
        .o_ia_offset  (ia_offset),
        .o_ia_gain    (ia_gain),
        .o_ii_offset  (ii_offset),
        .o_ii_gain    (ii_gain),
        .o_divider    (divider)
    );

    // simulation tick and time tag
    sim_tick_gen u_sim_tick_gen (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_divider    (divider),
        .o_sim_tick   (o_sim_tick),
        .o_time_tag   (o_time_tag)
    );

    afferent_channel #(.P_SEED(spindle_rack_pkg::SEED_IA)) u_ia_channel (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_tick   (o_sim_tick),
        .i_rate       (i_ia_rate),
        .i_offset     (ia_offset),
        .i_gain       (ia_gain),
        .o_current    (o_ia_current)
    );

    afferent_channel #(.P_SEED(spindle_rack_pkg::SEED_II)) u_ii_channel (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_tick   (o_sim_tick),
        .i_rate       (i_ii_rate),
        .i_offset     (ii_offset),
        .i_gain       (ii_gain),
        .o_current    (o_ii_current)
    );

    // spike rates back from the neuron array
    spike_rate_counter u_ia_counter (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_sim_tick    (o_sim_tick),
        .i_spike       (i_ia_spike),
        .o_spike_count (o_ia_spike_count)
    );

    spike_rate_counter u_ii_counter (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_sim_tick    (o_sim_tick),
        .i_spike       (i_ii_spike),
        .o_spike_count (o_ii_spike_count)
    );

endmodule

`default_nettype wire

//--- include/rack_model.svh
`ifndef RACK_MODEL_SVH
`define RACK_MODEL_SVH

// model state mirroring the rack after each tick
spindle_rack_pkg::rate_t       m_ia_offset, m_ii_offset;
spindle_rack_pkg::gain_t       m_ia_gain, m_ii_gain;
spindle_rack_pkg::param_word_t m_divider;
logic [31:0]                   m_lfsr_ia, m_lfsr_ii;
spindle_rack_pkg::time_t       m_time_tag;
spindle_rack_pkg::current_t    m_ia_current, m_ii_current;  // expected after a tick
int unsigned                   m_win_ia, m_win_ii;          // spikes in the open window
spindle_rack_pkg::count_t      m_ia_count, m_ii_count;      // expected latched counts

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? spindle_rack_pkg::LFSR_TAPS : 32'd0);
endfunction

// current above the noise field from offset removal, gain and shift
function automatic spindle_rack_pkg::current_t scaled_current(input int unsigned rate,
                                                              input int unsigned offset,
                                                              input int unsigned gain);
    longint unsigned net;
    net = (rate > offset) ? (rate - offset) : 0;
    net = ((net * gain) >> spindle_rack_pkg::GAIN_FRAC_BITS)
          << spindle_rack_pkg::CURRENT_SHIFT;
    return net[31:0] & ~((32'd1 << spindle_rack_pkg::NOISE_BITS) - 1);
endfunction

task automatic reset_model();
    m_ia_offset = spindle_rack_pkg::RESET_IA_OFFSET;
    m_ia_gain   = spindle_rack_pkg::RESET_IA_GAIN;
    m_ii_offset = spindle_rack_pkg::RESET_II_OFFSET;
    m_ii_gain   = spindle_rack_pkg::RESET_II_GAIN;
    m_divider   = spindle_rack_pkg::RESET_DIVIDER;
    m_lfsr_ia   = spindle_rack_pkg::SEED_IA;
    m_lfsr_ii   = spindle_rack_pkg::SEED_II;
    m_time_tag  = '0;
    m_ia_current = '0;
    m_ii_current = '0;
    m_win_ia    = 0;
    m_win_ii    = 0;
    m_ia_count  = '0;
    m_ii_count  = '0;
endtask

// host write as the bank decodes it
task automatic apply_write(input spindle_rack_pkg::param_addr_t addr,
                           input spindle_rack_pkg::param_word_t data);
    case (addr)
        spindle_rack_pkg::PARAM_ADDR_IA_OFFSET: m_ia_offset = data[15:0];
        spindle_rack_pkg::PARAM_ADDR_IA_GAIN:   m_ia_gain   = data[15:0];
        spindle_rack_pkg::PARAM_ADDR_II_OFFSET: m_ii_offset = data[15:0];
        spindle_rack_pkg::PARAM_ADDR_II_GAIN:   m_ii_gain   = data[15:0];
        spindle_rack_pkg::PARAM_ADDR_DIVIDER:   m_divider   = data;
        default: ;
    endcase
endtask

// one tick with the rates present on the tick edge
task automatic advance_tick(input spindle_rack_pkg::rate_t ia_rate,
                            input spindle_rack_pkg::rate_t ii_rate);
    m_ia_current = scaled_current(ia_rate, m_ia_offset, m_ia_gain)
                   | (m_lfsr_ia & ((32'd1 << spindle_rack_pkg::NOISE_BITS) - 1));
    m_ii_current = scaled_current(ii_rate, m_ii_offset, m_ii_gain)
                   | (m_lfsr_ii & ((32'd1 << spindle_rack_pkg::NOISE_BITS) - 1));
    m_lfsr_ia  = lfsr_step(m_lfsr_ia);
    m_lfsr_ii  = lfsr_step(m_lfsr_ii);
    m_time_tag = m_time_tag + 1;
    m_ia_count = (m_win_ia > 16'hFFFF) ? 16'hFFFF : m_win_ia[15:0];
    m_ii_count = (m_win_ii > 16'hFFFF) ? 16'hFFFF : m_win_ii[15:0];
    m_win_ia   = 0;
    m_win_ii   = 0;
endtask

`endif

//--- verif/tb_spindle_rack.sv
`default_nettype none
`timescale 1ns/1ps

module tb_spindle_rack;

    localparam int CLK_PERIOD    = 8;
    localparam int N_WRITES      = 10;    // random host writes including 5..7
    localparam int N_CUR_TICKS   = 12;
    localparam int N_NOISE_TICKS = 12;
    localparam int N_SPIKE_TICKS = 10;
    localparam int TICK_LIMIT    = 1000;  // cycles allowed for one tick
    localparam logic [31:0] NOISE_MASK = (32'd1 << spindle_rack_pkg::NOISE_BITS) - 1;
    // all test ticks at the slowest period taken twice
    localparam int WATCHDOG_NS = (N_CUR_TICKS + N_NOISE_TICKS + N_SPIKE_TICKS + 8)
                                 * (spindle_rack_pkg::RESET_DIVIDER + 1) * CLK_PERIOD * 2;

    logic                          ep50trig = 1'b0;
    logic                          reset_global;
    logic                          i_host_req, i_ia_spike, i_ii_spike;
    spindle_rack_pkg::param_addr_t i_host_addr;
    spindle_rack_pkg::param_word_t i_host_data;
    spindle_rack_pkg::rate_t       i_ia_rate, i_ii_rate;
    logic                          o_host_ack, o_sim_tick;
    spindle_rack_pkg::time_t       o_time_tag;
    spindle_rack_pkg::current_t    o_ia_current, o_ii_current;
    spindle_rack_pkg::count_t      o_ia_spike_count, o_ii_spike_count;

    // values for the next rising edge
    logic                          drv_reset, drv_req, drv_ia_spike, drv_ii_spike;
    spindle_rack_pkg::param_addr_t drv_addr;
    spindle_rack_pkg::param_word_t drv_data;
    spindle_rack_pkg::rate_t       drv_ia_rate, drv_ii_rate;

    spindle_rack_pkg::param_word_t tick_cnt_m;         // model of the divider count
    logic                          host_busy_m;        // model of the bank FSM
    logic                          ia_seen, ii_seen;   // last spike levels on the pins
    int                            errors = 0;
    int                            checks = 0;
    int                            test_errors = 0;    // errors before the current test
    int                            tests = 0;

    `include "rack_model.svh"

    always #(CLK_PERIOD / 2) ep50trig = ~ep50trig;

    spindle_rack_top UUT (.*);

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // drive on the rising edge then compare and step the model on the falling edge
    task automatic run_cycle();
        logic wr;
        @(posedge ep50trig);
        reset_global <= drv_reset;
        i_host_req   <= drv_req;
        i_host_addr  <= drv_addr;
        i_host_data  <= drv_data;
        i_ia_rate    <= drv_ia_rate;
        i_ii_rate    <= drv_ii_rate;
        i_ia_spike   <= drv_ia_spike;
        i_ii_spike   <= drv_ii_spike;
        @(negedge ep50trig);
        if (!reset_global)
        begin
            check_value("o_sim_tick", o_sim_tick, tick_cnt_m == m_divider);
            check_value("o_host_ack", o_host_ack, host_busy_m);
            check_value("o_time_tag", o_time_tag, m_time_tag);
            check_value("o_ia_current", o_ia_current, m_ia_current);
            check_value("o_ii_current", o_ii_current, m_ii_current);
            check_value("o_ia_spike_count", o_ia_spike_count, m_ia_count);
            check_value("o_ii_spike_count", o_ii_spike_count, m_ii_count);
            wr = !host_busy_m && i_host_req;  // req seen while idle
            host_busy_m = i_host_req;         // ack tracks req one edge late
            if (tick_cnt_m == m_divider)
            begin
                advance_tick(i_ia_rate, i_ii_rate);
                tick_cnt_m = '0;
            end
            else
                tick_cnt_m = tick_cnt_m + 1;
            if (wr)
                apply_write(i_host_addr, i_host_data);  // old values serve this edge's tick
            m_win_ia = m_win_ia + (i_ia_spike && !ia_seen);
            m_win_ii = m_win_ii + (i_ii_spike && !ii_seen);
            ia_seen = i_ia_spike;
            ii_seen = i_ii_spike;
        end
    endtask

    task automatic cycles_to_ack(input logic level, output int n);
        n = 1;
        run_cycle();
        while (o_host_ack !== level && n < 8)
        begin
            run_cycle();
            n++;
        end
    endtask

    // four-phase write with addr and data held until ack
    task automatic host_write(input spindle_rack_pkg::param_addr_t addr,
                              input spindle_rack_pkg::param_word_t data);
        int n;
        drv_req  = 1'b1;
        drv_addr = addr;
        drv_data = data;
        run_cycle();                      // req reaches the pins
        cycles_to_ack(1'b1, n);
        check_value("ack rise delay", n, 1);
        drv_req = 1'b0;
        run_cycle();
        cycles_to_ack(1'b0, n);
        check_value("ack fall delay", n, 1);
    endtask

    // returns with the tick high just before its edge
    task automatic wait_for_tick(output int cycles);
        cycles = 0;
        do
        begin
            run_cycle();
            cycles++;
        end
        while (!o_sim_tick && cycles < TICK_LIMIT);
        if (!o_sim_tick)
        begin
            $display("simulation tick missing after %0d cycles", TICK_LIMIT);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d mismatches", tests, name, errors - test_errors);
        test_errors = errors;
    endtask

    initial
    begin
        int                            cyc;
        int                            same;
        int                            n_ia, n_ii;
        logic                          allowed;
        logic [2:0]                    a;
        spindle_rack_pkg::rate_t       rate_ia, rate_ii;
        spindle_rack_pkg::current_t    exp_ia, exp_ii;
        logic [31:0]                   nz_ia, nz_ii;
        spindle_rack_pkg::param_word_t new_div;
        void'($urandom(35));
        reset_global = 1'b1;
        i_host_req   = 1'b0;
        i_host_addr  = '0;
        i_host_data  = '0;
        i_ia_rate    = '0;
        i_ii_rate    = '0;
        i_ia_spike   = 1'b0;
        i_ii_spike   = 1'b0;
        drv_reset    = 1'b1;
        drv_req      = 1'b0;
        drv_addr     = '0;
        drv_data     = '0;
        drv_ia_rate  = '0;
        drv_ii_rate  = '0;
        drv_ia_spike = 1'b0;
        drv_ii_spike = 1'b0;
        tick_cnt_m   = '0;
        host_busy_m  = 1'b0;
        ia_seen      = 1'b0;
        ii_seen      = 1'b0;
        reset_model();
        repeat (10) run_cycle();

        drv_reset = 1'b0;
        run_cycle();                                       // release edge shows reset values
        check_value("reset outputs", o_host_ack | o_time_tag | o_ia_current | o_ii_current
                    | o_ia_spike_count | o_ii_spike_count, 0);
        wait_for_tick(cyc);
        check_value("first tick cycle", cyc + 1, spindle_rack_pkg::RESET_DIVIDER + 1);
        end_test("reset");

        for (int i = 0; i < N_WRITES; i++)
        begin
            a = (i < 3) ? 3'(5 + i) : 3'($urandom_range(3));  // unmapped first and no divider
            host_write(a, $urandom());
        end
        wait_for_tick(cyc);
        new_div = 20 + $urandom_range(40);
        host_write(spindle_rack_pkg::PARAM_ADDR_DIVIDER, new_div);  // lands just after a tick
        wait_for_tick(cyc);
        repeat (3)
        begin
            wait_for_tick(cyc);
            check_value("tick interval", cyc, new_div + 1);
        end
        end_test("host");

        for (int i = 0; i < N_CUR_TICKS; i++)
        begin
            if (i % 4 == 0)
            begin
                host_write(spindle_rack_pkg::PARAM_ADDR_IA_OFFSET, $urandom_range(300));
                host_write(spindle_rack_pkg::PARAM_ADDR_IA_GAIN, $urandom_range(1023));
                host_write(spindle_rack_pkg::PARAM_ADDR_II_OFFSET, $urandom_range(300));
                host_write(spindle_rack_pkg::PARAM_ADDR_II_GAIN, $urandom_range(1023));
            end
            // odd ticks sit at or below the offset
            rate_ia = (i % 2) ? $urandom_range(m_ia_offset) : $urandom_range(1000);
            rate_ii = (i % 2) ? $urandom_range(m_ii_offset) : $urandom_range(1000);
            drv_ia_rate = rate_ia;
            drv_ii_rate = rate_ii;
            wait_for_tick(cyc);
            run_cycle();                                   // tick edge
            exp_ia = scaled_current(rate_ia, m_ia_offset, m_ia_gain);
            exp_ii = scaled_current(rate_ii, m_ii_offset, m_ii_gain);
            check_value("ia current above noise", o_ia_current & ~NOISE_MASK, exp_ia);
            check_value("ii current above noise", o_ii_current & ~NOISE_MASK, exp_ii);
        end
        end_test("currents");

        same = 0;
        for (int i = 0; i < N_NOISE_TICKS; i++)
        begin
            drv_ia_rate = $urandom_range(1000);
            drv_ii_rate = $urandom_range(1000);
            nz_ia = m_lfsr_ia & NOISE_MASK;               // lfsr before this tick's step
            nz_ii = m_lfsr_ii & NOISE_MASK;
            wait_for_tick(cyc);
            run_cycle();
            check_value("ia noise", o_ia_current & NOISE_MASK, nz_ia);
            check_value("ii noise", o_ii_current & NOISE_MASK, nz_ii);
            same += (((o_ia_current ^ o_ii_current) & NOISE_MASK) == 0);
        end
        check_value("channels differ in noise", same < N_NOISE_TICKS, 1);
        end_test("noise");

        for (int w = 0; w < N_SPIKE_TICKS; w++)
        begin
            n_ia = 0;
            n_ii = 0;
            cyc  = 0;
            do
            begin
                // sync delay plus margin on both sides of each tick
                allowed = (tick_cnt_m >= 5) && (tick_cnt_m + 6 <= m_divider);
                drv_ia_spike = !drv_ia_spike && allowed && ($urandom_range(2) == 0);
                drv_ii_spike = !drv_ii_spike && allowed && ($urandom_range(1) == 0);
                n_ia += drv_ia_spike;
                n_ii += drv_ii_spike;
                run_cycle();
                cyc++;
            end
            while (!o_sim_tick && cyc < TICK_LIMIT);
            run_cycle();                                   // window closes here
            check_value("ia window count", o_ia_spike_count, n_ia);
            check_value("ii window count", o_ii_spike_count, n_ii);
            check_value("time tag", o_time_tag, m_time_tag);
        end
        end_test("spikes");

        $display("%0d tests, %0d checks, %0d mismatches", tests, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
src/spindle_rack_pkg.sv
src/param_bank.sv
src/sim_tick_gen.sv
src/afferent_channel.sv
src/spike_rate_counter.sv
src/spindle_rack_top.sv
verif/tb_spindle_rack.sv
